//--- hw/cpuPkg.sv
package cpuPkg;

    // issue width and register count
    localparam int SLOTS = 2;
    localparam int REGS = 32;

    // cp0 register numbers
    localparam logic [4:0] CP0_STATUS = 5'd12;
    localparam logic [4:0] CP0_CAUSE = 5'd13;
    localparam logic [4:0] CP0_EPC = 5'd14;

    // field positions inside status and cause
    localparam int STATUS_EXL_BIT = 1;
    localparam int CAUSE_CODE_LSB = 2;

    typedef logic [31:0] wordT;
    typedef logic [4:0] regAddrT;
    typedef logic [4:0] cp0AddrT;
    typedef logic [4:0] excCodeT;

    // what the instruction does to cp0 state
    typedef enum logic [1:0] {
        NORMAL,
        EXCEPTION,
        ERET
    } cp0TypeT;

    // decoded control flags carried down the pipe
    typedef struct packed {
        logic regWrite;
        logic memToReg;
        logic cp0ToReg;
        logic loToReg;
        logic hiToReg;
        logic hiWrite;
        logic loWrite;
        logic cp0Write;
    } ctlT;

    // one slot leaving the memory stage
    typedef struct packed {
        logic valid;
        wordT pc;
        ctlT ctl;
        cp0TypeT ctype;
        excCodeT excCode;
        regAddrT rdst;
        cp0AddrT cp0Addr;
        wordT aluOut;
        // memory read data
        wordT rd;
    } memoryDataT;

    // one slot's general register commit
    typedef struct packed {
        logic valid;
        wordT pc;
        regAddrT wa;
        wordT wd;
        ctlT ctl;
    } writebackDataT;

    // merged hi/lo/cp0 commit for the whole bundle
    typedef struct packed {
        logic hiWe;
        wordT hiData;
        logic loWe;
        wordT loData;
        logic cp0We;
        cp0AddrT cp0Addr;
        wordT cp0Data;
        logic excTake;
        wordT excPc;
        excCodeT excCode;
        logic eretTake;
    } specialWriteT;

    // architectural special registers
    typedef struct packed {
        wordT hi;
        wordT lo;
        wordT status;
        wordT cause;
        wordT epc;
    } specialStateT;

endpackage

//--- hw/memWbReg.sv
`timescale 1ns/100ps

module memWbReg import cpuPkg::*; (
    input logic clk,
    input logic rstN,
    input memoryDataT memIn [SLOTS-1:0],
    output memoryDataT memLatched [SLOTS-1:0]
);

    // mem to wb stage boundary
    always_ff @(posedge clk) begin
        for (int i = 0; i < SLOTS; i++) begin
            // payload follows input every edge
            memLatched[i] <= memIn[i];
            // only valid needs clearing
            if (!rstN) begin
                memLatched[i].valid <= 1'b0;
            end
        end
    end

endmodule

//--- hw/writebackSelect.sv
`timescale 1ns/100ps

module writebackSelect import cpuPkg::*; (
    input memoryDataT memLatched [SLOTS-1:0],
    input wordT cp0Rd [SLOTS-1:0],
    input wordT hiRd,
    input wordT loRd,
    output writebackDataT wbData [SLOTS-1:0],
    output specialWriteT specialWr
);

    // older slot trapping or returning kills the younger one
    logic killYounger;
    logic squash [SLOTS-1:0];
    logic live [SLOTS-1:0];
    // first slot raising an exception or eret
    logic evtValid;
    logic evtSlot;

    assign killYounger = memLatched[0].valid && (memLatched[0].ctype != NORMAL);
    assign squash[0] = (memLatched[0].ctype != NORMAL);
    assign squash[1] = (memLatched[1].ctype != NORMAL) || killYounger;

    for (genvar i = 0; i < SLOTS; i++) begin : gSlot
        assign live[i] = memLatched[i].valid && !squash[i];

        assign wbData[i].valid = live[i] && memLatched[i].ctl.regWrite;
        assign wbData[i].pc = memLatched[i].pc;
        assign wbData[i].wa = memLatched[i].rdst;
        assign wbData[i].ctl = memLatched[i].ctl;

        // source priority, hi first and alu last
        always_comb begin
            if (memLatched[i].ctl.hiToReg) begin
                wbData[i].wd = hiRd;
            end else if (memLatched[i].ctl.loToReg) begin
                wbData[i].wd = loRd;
            end else if (memLatched[i].ctl.cp0ToReg) begin
                wbData[i].wd = cp0Rd[i];
            end else if (memLatched[i].ctl.memToReg) begin
                wbData[i].wd = memLatched[i].rd;
            end else if (memLatched[i].ctl.regWrite) begin
                wbData[i].wd = memLatched[i].aluOut;
            end else begin
                wbData[i].wd = '0;
            end
        end
    end

    // scan downward so slot 0 takes precedence
    always_comb begin
        evtValid = 1'b0;
        evtSlot = 1'b0;
        for (int i = SLOTS - 1; i >= 0; i--) begin
            if (memLatched[i].valid && (memLatched[i].ctype != NORMAL)) begin
                evtValid = 1'b1;
                evtSlot = i[0];
            end
        end
    end

    always_comb begin
        specialWr = '0;
        // ascending order, so slot 1 overwrites slot 0
        for (int i = 0; i < SLOTS; i++) begin
            if (live[i] && memLatched[i].ctl.hiWrite) begin
                specialWr.hiWe = 1'b1;
                specialWr.hiData = memLatched[i].aluOut;
            end
            if (live[i] && memLatched[i].ctl.loWrite) begin
                specialWr.loWe = 1'b1;
                specialWr.loData = memLatched[i].aluOut;
            end
            // mtc0 data comes through the alu
            if (live[i] && memLatched[i].ctl.cp0Write) begin
                specialWr.cp0We = 1'b1;
                specialWr.cp0Addr = memLatched[i].cp0Addr;
                specialWr.cp0Data = memLatched[i].aluOut;
            end
        end
        // trap event, at most one per bundle
        specialWr.excTake = evtValid && (memLatched[evtSlot].ctype == EXCEPTION);
        specialWr.eretTake = evtValid && (memLatched[evtSlot].ctype == ERET);
        specialWr.excPc = memLatched[evtSlot].pc;
        specialWr.excCode = memLatched[evtSlot].excCode;
    end

endmodule

//--- hw/regFile.sv
`timescale 1ns/100ps

module regFile import cpuPkg::*; (
    input logic clk,
    input logic rstN,
    input writebackDataT wbData [SLOTS-1:0],
    input regAddrT rdAddr [SLOTS-1:0],
    output wordT rdData [SLOTS-1:0]
);

    wordT regs [REGS];

    // two write ports
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int r = 0; r < REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // slot 1 last, so it wins a same-address write
            for (int i = 0; i < SLOTS; i++) begin
                // r0 never written
                if (wbData[i].valid && (wbData[i].wa != '0)) begin
                    regs[wbData[i].wa] <= wbData[i].wd;
                end
            end
        end
    end

    // async reads, no bypass from the commit in flight
    for (genvar i = 0; i < SLOTS; i++) begin : gRead
        assign rdData[i] = (rdAddr[i] == '0) ? '0 : regs[rdAddr[i]];
    end

endmodule

//--- hw/specialRegs.sv
`timescale 1ns/100ps

module specialRegs import cpuPkg::*; (
    input logic clk,
    input logic rstN,
    input specialWriteT specialWr,
    input cp0AddrT cp0Addr [SLOTS-1:0],
    output wordT hiRd,
    output wordT loRd,
    output wordT cp0Rd [SLOTS-1:0],
    output specialStateT specialState
);

    specialStateT state;
    specialStateT stateNext;

    assign hiRd = state.hi;
    assign loRd = state.lo;
    assign specialState = state;

    // cp0 read decode per slot
    for (genvar i = 0; i < SLOTS; i++) begin : gCp0Read
        always_comb begin
            case (cp0Addr[i])
                CP0_STATUS: cp0Rd[i] = state.status;
                CP0_CAUSE: cp0Rd[i] = state.cause;
                CP0_EPC: cp0Rd[i] = state.epc;
                // unimplemented cp0 register
                default: cp0Rd[i] = '0;
            endcase
        end
    end

    always_comb begin
        stateNext = state;
        if (specialWr.hiWe) begin
            stateNext.hi = specialWr.hiData;
        end
        if (specialWr.loWe) begin
            stateNext.lo = specialWr.loData;
        end
        // mtc0 first
        if (specialWr.cp0We) begin
            case (specialWr.cp0Addr)
                CP0_STATUS: stateNext.status = specialWr.cp0Data;
                CP0_CAUSE: stateNext.cause = specialWr.cp0Data;
                CP0_EPC: stateNext.epc = specialWr.cp0Data;
                default: ;
            endcase
        end
        // then trap entry on top
        if (specialWr.excTake) begin
            stateNext.epc = specialWr.excPc;
            stateNext.cause[CAUSE_CODE_LSB +: $bits(excCodeT)] = specialWr.excCode;
            stateNext.status[STATUS_EXL_BIT] = 1'b1;
        end
        // eret leaves exception level
        if (specialWr.eretTake) begin
            stateNext.status[STATUS_EXL_BIT] = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= '0;
        end else begin
            state <= stateNext;
        end
    end

endmodule

//--- hw/writebackTop.sv
`timescale 1ns/100ps

module writebackTop import cpuPkg::*; (
    input logic clk,
    input logic rstN,
    input memoryDataT memIn [SLOTS-1:0],
    input regAddrT rdAddr [SLOTS-1:0],
    output writebackDataT wbOut [SLOTS-1:0],
    output wordT rdData [SLOTS-1:0],
    output specialStateT specialState
);

    memoryDataT memLatched [SLOTS-1:0];
    cp0AddrT cp0Addr [SLOTS-1:0];
    wordT cp0Rd [SLOTS-1:0];
    wordT hiRd;
    wordT loRd;
    specialWriteT specialWr;

    // mfc0 source address per latched slot
    for (genvar i = 0; i < SLOTS; i++) begin : gCp0Addr
        assign cp0Addr[i] = memLatched[i].cp0Addr;
    end

    memWbReg uMemWbReg (
        .clk(clk),
        .rstN(rstN),
        .memIn(memIn),
        .memLatched(memLatched)
    );

    writebackSelect uSelect (
        .memLatched(memLatched),
        .cp0Rd(cp0Rd),
        .hiRd(hiRd),
        .loRd(loRd),
        .wbData(wbOut),
        .specialWr(specialWr)
    );

    regFile uRegFile (
        .clk(clk),
        .rstN(rstN),
        .wbData(wbOut),
        .rdAddr(rdAddr),
        .rdData(rdData)
    );

    specialRegs uSpecialRegs (
        .clk(clk),
        .rstN(rstN),
        .specialWr(specialWr),
        .cp0Addr(cp0Addr),
        .hiRd(hiRd),
        .loRd(loRd),
        .cp0Rd(cp0Rd),
        .specialState(specialState)
    );

endmodule

//--- testbench/writebackChecker.sv
`timescale 1ns/100ps

module writebackChecker import cpuPkg::*; (
    input logic clk,
    input logic rstN,
    input memoryDataT memIn [SLOTS-1:0],
    input regAddrT rdAddr [SLOTS-1:0],
    input writebackDataT wbOut [SLOTS-1:0],
    input wordT rdData [SLOTS-1:0],
    input specialStateT specialState,
    output int errors,
    output int checks
);

    // shadow architectural state
    wordT shadowRegs [REGS];
    specialStateT shadowState;
    // model of the bundle sitting in the stage register
    memoryDataT pending [SLOTS];
    // set once the first reset edge has been seen
    logic primed = 1'b0;

    initial begin
        errors = 0;
        checks = 0;
    end

    function automatic logic slotLive(int s);
        if (!pending[s].valid || pending[s].ctype != NORMAL) begin
            return 1'b0;
        end
        // an older trap or eret takes the younger slot with it
        if (s == 1 && pending[0].valid && pending[0].ctype != NORMAL) begin
            return 1'b0;
        end
        return 1'b1;
    endfunction

    function automatic wordT cp0Value(cp0AddrT a);
        case (a)
            CP0_STATUS: return shadowState.status;
            CP0_CAUSE: return shadowState.cause;
            CP0_EPC: return shadowState.epc;
            default: return '0;
        endcase
    endfunction

    // expected writeback for one slot against pre-commit state
    function automatic writebackDataT expectWb(int s);
        writebackDataT e;
        memoryDataT m;
        m = pending[s];
        e.valid = slotLive(s) && m.ctl.regWrite;
        e.pc = m.pc;
        e.wa = m.rdst;
        e.ctl = m.ctl;
        if (m.ctl.hiToReg) begin
            e.wd = shadowState.hi;
        end else if (m.ctl.loToReg) begin
            e.wd = shadowState.lo;
        end else if (m.ctl.cp0ToReg) begin
            e.wd = cp0Value(m.cp0Addr);
        end else if (m.ctl.memToReg) begin
            e.wd = m.rd;
        end else if (m.ctl.regWrite) begin
            e.wd = m.aluOut;
        end else begin
            e.wd = '0;
        end
        return e;
    endfunction

    // apply the pending bundle to the shadow state
    task automatic commitBundle();
        writebackDataT wb [SLOTS];
        memoryDataT trapSlot;
        memoryDataT moveSlot;
        logic trapSeen;
        logic moveSeen;
        for (int s = 0; s < SLOTS; s++) begin
            wb[s] = expectWb(s);
        end
        // r0 stays zero and the younger slot goes last
        for (int s = 0; s < SLOTS; s++) begin
            if (wb[s].valid && wb[s].wa != '0) begin
                shadowRegs[wb[s].wa] = wb[s].wd;
            end
        end
        moveSeen = 1'b0;
        moveSlot = '0;
        for (int s = 0; s < SLOTS; s++) begin
            if (slotLive(s)) begin
                if (pending[s].ctl.hiWrite) begin
                    shadowState.hi = pending[s].aluOut;
                end
                if (pending[s].ctl.loWrite) begin
                    shadowState.lo = pending[s].aluOut;
                end
                // a bundle has one mtc0 port and the younger live mtc0 takes it
                if (pending[s].ctl.cp0Write) begin
                    moveSeen = 1'b1;
                    moveSlot = pending[s];
                end
            end
        end
        if (moveSeen) begin
            case (moveSlot.cp0Addr)
                CP0_STATUS: shadowState.status = moveSlot.aluOut;
                CP0_CAUSE: shadowState.cause = moveSlot.aluOut;
                CP0_EPC: shadowState.epc = moveSlot.aluOut;
                default: ;
            endcase
        end
        // oldest valid non-normal slot decides the trap event
        trapSeen = 1'b1;
        if (pending[0].valid && pending[0].ctype != NORMAL) begin
            trapSlot = pending[0];
        end else if (pending[1].valid && pending[1].ctype != NORMAL) begin
            trapSlot = pending[1];
        end else begin
            trapSeen = 1'b0;
            trapSlot = '0;
        end
        if (trapSeen && trapSlot.ctype == EXCEPTION) begin
            shadowState.epc = trapSlot.pc;
            shadowState.cause[CAUSE_CODE_LSB +: 5] = trapSlot.excCode;
            shadowState.status[STATUS_EXL_BIT] = 1'b1;
        end else if (trapSeen && trapSlot.ctype == ERET) begin
            shadowState.status[STATUS_EXL_BIT] = 1'b0;
        end
    endtask

    task automatic compare(string name, logic [159:0] expected, logic [159:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("CHECK FAILED time=%0t signal=%s expected=%0h actual=%0h",
                $time, name, expected, actual);
        end
    endtask

    // model advances on the edge while inputs are stable
    always @(posedge clk) begin
        if (!rstN) begin
            for (int r = 0; r < REGS; r++) begin
                shadowRegs[r] = '0;
            end
            shadowState = '0;
            primed = 1'b1;
        end else if (primed) begin
            commitBundle();
        end
        for (int s = 0; s < SLOTS; s++) begin
            pending[s] = memIn[s];
            if (!rstN) begin
                pending[s].valid = 1'b0;
            end
        end
    end

    // outputs compared mid-cycle
    always @(negedge clk) begin : compareOutputs
        wordT expRd;
        if (primed) begin
            for (int s = 0; s < SLOTS; s++) begin
                compare($sformatf("wbOut[%0d]", s), expectWb(s), wbOut[s]);
                expRd = (rdAddr[s] == '0) ? '0 : shadowRegs[rdAddr[s]];
                compare($sformatf("rdData[%0d]", s), expRd, rdData[s]);
            end
            compare("specialState", shadowState, specialState);
        end
    end

endmodule

//--- testbench/tbWriteback.sv
`timescale 1ns/100ps

module tbWriteback import cpuPkg::*; ();

    // flag bits from msb down
    // regWrite memToReg cp0ToReg loToReg hiToReg hiWrite loWrite cp0Write
    localparam ctlT ctlNone = 8'h00;
    localparam ctlT ctlAlu = 8'h80;
    localparam ctlT ctlLoad = 8'hC0;
    localparam ctlT ctlMfc0 = 8'hA0;
    localparam ctlT ctlMflo = 8'h90;
    localparam ctlT ctlMfhi = 8'h88;
    localparam ctlT ctlAllSrc = 8'hF8;
    localparam ctlT ctlMthi = 8'h04;
    localparam ctlT ctlMtlo = 8'h02;
    localparam ctlT ctlMtc0 = 8'h01;
    localparam ctlT ctlAluWrites = 8'h87;
    // roughly 500 random plus directed and reset cycles
    localparam int stimCycles = 600;
    localparam int timeoutCycles = 3 * stimCycles + 200;

    logic clk;
    logic rstN;
    memoryDataT memIn [SLOTS-1:0];
    regAddrT rdAddr [SLOTS-1:0];
    writebackDataT wbOut [SLOTS-1:0];
    wordT rdData [SLOTS-1:0];
    specialStateT specialState;
    int errors;
    int checks;
    int errBase = 0;
    int testCount = 0;
    int cycleCount = 0;
    wordT pcNext = 32'hbfc0_0000;
    memoryDataT bubble = '0;

    writebackTop DUT (
        .clk(clk),
        .rstN(rstN),
        .memIn(memIn),
        .rdAddr(rdAddr),
        .wbOut(wbOut),
        .rdData(rdData),
        .specialState(specialState)
    );

    writebackChecker uChecker (
        .clk(clk),
        .rstN(rstN),
        .memIn(memIn),
        .rdAddr(rdAddr),
        .wbOut(wbOut),
        .rdData(rdData),
        .specialState(specialState),
        .errors(errors),
        .checks(checks)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ends a hung run
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= timeoutCycles) begin
            $display("run did not finish within %0d cycles, stopping", timeoutCycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic memoryDataT op(ctlT ctl, regAddrT rdst, cp0AddrT cp0Addr,
                                      wordT aluOut, wordT rd);
        memoryDataT m;
        m = '0;
        m.valid = 1'b1;
        m.ctl = ctl;
        m.ctype = NORMAL;
        m.rdst = rdst;
        m.cp0Addr = cp0Addr;
        m.aluOut = aluOut;
        m.rd = rd;
        return m;
    endfunction

    // trapping slot whose squashed mtc0 would hit epc
    function automatic memoryDataT trap(ctlT ctl, cp0TypeT ctype, excCodeT code,
                                        regAddrT rdst, wordT aluOut);
        memoryDataT m;
        m = op(ctl, rdst, CP0_EPC, aluOut, aluOut);
        m.ctype = ctype;
        m.excCode = code;
        return m;
    endfunction

    function automatic memoryDataT randomSlot();
        memoryDataT m;
        int pick;
        pick = $urandom % 8;
        m = '0;
        m.valid = ($urandom % 4) != 0;
        m.ctl = ctlT'($urandom);
        m.ctype = (pick == 0) ? EXCEPTION : (pick == 1) ? ERET : NORMAL;
        m.excCode = excCodeT'($urandom);
        m.rdst = regAddrT'($urandom);
        // 11 and 15 are unknown cp0 numbers
        m.cp0Addr = cp0AddrT'(11 + $urandom % 5);
        m.aluOut = $urandom;
        m.rd = $urandom;
        return m;
    endfunction

    // drive one bundle just after the edge
    task automatic step(memoryDataT b0, memoryDataT b1, regAddrT a0, regAddrT a1);
        @(posedge clk);
        #2;
        b0.pc = pcNext;
        b1.pc = pcNext + 4;
        pcNext = pcNext + 8;
        memIn[0] = b0;
        memIn[1] = b1;
        rdAddr[0] = a0;
        rdAddr[1] = a1;
    endtask

    task automatic idle(int n, regAddrT a0, regAddrT a1);
        repeat (n) step(bubble, bubble, a0, a1);
    endtask

    task automatic reportTest(string name);
        @(negedge clk);
        #1;
        $display("test %s finished, %0d errors", name, errors - errBase);
        errBase = errors;
        testCount++;
    endtask

    initial begin
        void'($urandom(59652));
        rstN = 1'b0;
        memIn[0] = '0;
        memIn[1] = '0;
        rdAddr[0] = '0;
        rdAddr[1] = '0;
        repeat (8) @(posedge clk);
        #2;
        rstN = 1'b1;

        // alu, load, then no regWrite giving zero
        step(op(ctlAlu, 3, 0, 32'h1111_0001, 0),
            op(ctlLoad, 4, 0, 32'hdead_0000, 32'h2222_0002), 0, 0);
        step(op(ctlNone, 5, 0, 32'h3333_0003, 32'h4444), bubble, 3, 4);
        idle(2, 3, 4);
        idle(2, 5, 0);
        reportTest("source selection");

        // mfhi beside mthi sees the old hi
        step(op(ctlMthi, 0, 0, 32'haaaa_0001, 0), op(ctlMtlo, 0, 0, 32'hbbbb_0002, 0), 0, 0);
        step(op(ctlMthi, 0, 0, 32'hcccc_0003, 0), op(ctlMfhi, 6, 0, 0, 0), 6, 0);
        step(op(ctlMfhi, 7, 0, 0, 0), op(ctlMflo, 8, 0, 0, 0), 6, 7);
        step(op(ctlAllSrc, 9, CP0_STATUS, 32'h5, 32'h6), bubble, 7, 8);
        idle(3, 8, 9);
        reportTest("hi lo");

        // mfc0 in the bundle after each mtc0 reads the new word
        step(op(ctlMtc0, 0, CP0_STATUS, 32'h0000_ff01, 0), bubble, 0, 0);
        step(op(ctlMtc0, 0, CP0_CAUSE, 32'h0000_0300, 0),
            op(ctlMfc0, 10, CP0_STATUS, 0, 0), 0, 0);
        step(op(ctlMtc0, 0, CP0_EPC, 32'hbfc0_0100, 0),
            op(ctlMfc0, 11, CP0_CAUSE, 0, 0), 10, 0);
        step(op(ctlMfc0, 12, CP0_EPC, 0, 0), op(ctlMfc0, 13, 5'd3, 0, 0), 10, 11);
        idle(3, 12, 13);
        reportTest("cp0 moves");

        // slot 0 trap kills both, slot 1 trap only itself, then eret
        step(trap(ctlAluWrites, EXCEPTION, 5'd5, 20, 32'h9999),
            op(ctlAluWrites, 21, 0, 32'h1357, 0), 20, 21);
        step(op(ctlAlu, 22, 0, 32'h2468, 0),
            trap(ctlAluWrites, EXCEPTION, 5'd9, 23, 32'hffff), 20, 21);
        step(trap(ctlAlu, ERET, 0, 24, 32'h1), op(ctlAlu, 25, 0, 32'h2, 0), 22, 23);
        idle(3, 24, 25);
        reportTest("exceptions");

        step(op(ctlAlu, 14, 0, 32'h1, 0), op(ctlAlu, 14, 0, 32'h2, 0), 14, 0);
        step(op(ctlAlu, 0, 0, 32'hffff, 0), op(ctlLoad, 0, 0, 0, 32'heeee), 14, 0);
        idle(2, 14, 0);
        // reset with valid bundles on the input
        step(op(ctlAlu, 15, 0, 32'h77, 0), op(ctlAlu, 16, 0, 32'h88, 0), 15, 16);
        rstN = 1'b0;
        step(op(ctlAlu, 15, 0, 32'h77, 0), op(ctlAlu, 16, 0, 32'h88, 0), 15, 16);
        step(op(ctlAlu, 17, 0, 32'h99, 0), bubble, 15, 17);
        rstN = 1'b1;
        idle(3, 15, 17);
        reportTest("collisions and reset");

        for (int n = 0; n < 500; n++) begin
            step(randomSlot(), randomSlot(), regAddrT'($urandom), regAddrT'($urandom));
        end
        idle(3, 0, 0);
        reportTest("random bundles");

        $display("%0d tests, %0d checks, %0d errors", testCount, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- project.f
hw/cpuPkg.sv
hw/memWbReg.sv
hw/writebackSelect.sv
hw/regFile.sv
hw/specialRegs.sv
hw/writebackTop.sv
testbench/writebackChecker.sv
testbench/tbWriteback.sv
